// File: logic/rvPkg.sv
`default_nettype none

package rvPkg;

    //////////////////////////////////////////////////////////////
    // Base opcodes of the supported RV32I subset
    localparam logic [6:0] OpR      = 7'b0110011;
    localparam logic [6:0] OpI      = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpLui    = 7'b0110111;

    //////////////////////////////////////////////////////////////
    // Selector encodings shared by the controller and the datapath
    typedef enum logic [2:0] {
        ImmI, ImmS, ImmB, ImmJ, ImmU
    } immSrcT;

    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluSlt
    } aluCtrlT;

    typedef enum logic [1:0] {
        FwdNone, FwdWb, FwdMem
    } fwdSelT;

    typedef enum logic [1:0] {
        ResAlu, ResMem, ResPcPlus4, ResImm
    } resultSrcT;

    //////////////////////////////////////////////////////////////
    // Predictor geometry
    localparam int NumBtbEntries = 16;
    localparam int NumGhrBits    = 4;
    localparam int BtbIdxBits    = $clog2(NumBtbEntries);
    // PCs are word aligned so the two low bits take no part in index or tag
    localparam int BtbTagBits    = 32 - BtbIdxBits - 2;

    localparam logic [31:0] PcStart = 32'h0000_0000;

endpackage

`default_nettype wire

// File: logic/rvRegFile.sv
`default_nettype none

module rvRegFile (
    input  logic        clk,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        we_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // A same-cycle write is passed through so Writeback reaches Decode
    assign rd1_o = (rs1_i == 5'd0) ? 32'h0 :
                   (we_i && rs1_i == rd_i) ? wd_i : regs[rs1_i];
    assign rd2_o = (rs2_i == 5'd0) ? 32'h0 :
                   (we_i && rs2_i == rd_i) ? wd_i : regs[rs2_i];

endmodule

`default_nettype wire

// File: logic/rvAlu.sv
`default_nettype none

module rvAlu (
    input  logic [31:0]    a_i,
    input  logic [31:0]    b_i,
    input  rvPkg::aluCtrlT ctrl_i,
    output logic [31:0]    result_o,
    output logic           zero_o
);
    import rvPkg::*;

    logic [31:0] diff;

    assign diff = a_i - b_i;

    always_comb begin
        case (ctrl_i)
            AluAdd:  result_o = a_i + b_i;
            AluSub:  result_o = diff;
            AluAnd:  result_o = a_i & b_i;
            AluOr:   result_o = a_i | b_i;
            AluSlt:  result_o = {31'h0, $signed(a_i) < $signed(b_i)};
            default: result_o = 32'h0;
        endcase
    end

    // beq resolves on this flag with the ALU set to subtract
    assign zero_o = (result_o == 32'h0);

endmodule

`default_nettype wire

// File: logic/rvBranchPredictor.sv
`default_nettype none

module rvBranchPredictor (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [31:0]                  pcF_i,
    output logic                         predTakenF_o,
    output logic [31:0]                  predTargetF_o,
    output logic [rvPkg::NumGhrBits-1:0] phtIndexF_o,
    input  logic                         updateE_i,
    input  logic                         isBranchE_i,
    input  logic                         takenE_i,
    input  logic [31:0]                  pcE_i,
    input  logic [31:0]                  targetE_i,
    input  logic [rvPkg::NumGhrBits-1:0] phtIndexE_i
);
    import rvPkg::*;

    localparam int PhtEntries = 2 ** NumGhrBits;

    logic                  btbValid  [NumBtbEntries];
    logic                  btbJump   [NumBtbEntries];
    logic [BtbTagBits-1:0] btbTag    [NumBtbEntries];
    logic [31:0]           btbTarget [NumBtbEntries];
    logic [1:0]            pht       [PhtEntries];
    logic [NumGhrBits-1:0] ghr;
    logic [BtbIdxBits-1:0] idxF, idxE;
    logic                  btbHitF, btbWe, phtWe;

    assign idxF = pcF_i[BtbIdxBits+1:2];
    assign idxE = pcE_i[BtbIdxBits+1:2];

    //////////////////////////////////////////////////////////////
    // Fetch-side lookup
    assign btbHitF       = btbValid[idxF] && (btbTag[idxF] == pcF_i[31:BtbIdxBits+2]);
    assign phtIndexF_o   = ghr ^ pcF_i[NumGhrBits+1:2];
    assign predTakenF_o  = btbHitF && (btbJump[idxF] || pht[phtIndexF_o][1]);
    assign predTargetF_o = btbTarget[idxF];

    //////////////////////////////////////////////////////////////
    // Execute-side training
    assign btbWe = updateE_i && takenE_i;
    assign phtWe = updateE_i && isBranchE_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < NumBtbEntries; i++) begin
                btbValid[i] <= 1'b0;
            end
            // Every counter starts weakly not-taken
            for (int i = 0; i < PhtEntries; i++) begin
                pht[i] <= 2'b01;
            end
        end else begin
            if (btbWe) begin
                btbValid[idxE] <= 1'b1;
            end
            if (phtWe) begin
                ghr <= {ghr[NumGhrBits-2:0], takenE_i};
                if (takenE_i && pht[phtIndexE_i] != 2'b11) begin
                    pht[phtIndexE_i] <= pht[phtIndexE_i] + 2'b01;
                end else if (!takenE_i && pht[phtIndexE_i] != 2'b00) begin
                    pht[phtIndexE_i] <= pht[phtIndexE_i] - 2'b01;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btbWe) begin
            btbJump[idxE]   <= !isBranchE_i;
            btbTag[idxE]    <= pcE_i[31:BtbIdxBits+2];
            btbTarget[idxE] <= targetE_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/rvController.sv
`default_nettype none

module rvController (
    input  logic             clk,
    input  logic             reset,
    input  logic [6:0]       op_i,
    input  logic [2:0]       funct3_i,
    input  logic             funct7b5_i,
    input  logic [4:0]       rs1D_i,
    input  logic [4:0]       rs2D_i,
    input  logic [4:0]       rs1E_i,
    input  logic [4:0]       rs2E_i,
    input  logic [4:0]       rdE_i,
    input  logic [4:0]       rdM_i,
    input  logic [4:0]       rdW_i,
    input  logic             mispredictE_i,
    output rvPkg::immSrcT    immSrcD_o,
    output logic             aluSrcE_o,
    output rvPkg::aluCtrlT   aluCtrlE_o,
    output rvPkg::resultSrcT resultSrcM_o,
    output rvPkg::resultSrcT resultSrcW_o,
    output logic             memWriteM_o,
    output logic             regWriteW_o,
    output rvPkg::fwdSelT    forwardAE_o,
    output rvPkg::fwdSelT    forwardBE_o,
    output logic             stallF_o,
    output logic             stallD_o,
    output logic             flushD_o,
    output logic             flushE_o
);
    import rvPkg::*;

    logic      regWriteD, memWriteD, aluSrcD;
    resultSrcT resultSrcD, resultSrcE;
    aluCtrlT   aluCtrlD;
    logic      regWriteE, memWriteE, regWriteM;
    logic      loadUseD;

    //////////////////////////////////////////////////////////////
    // Main decoder that turns unknown opcodes into a bubble
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        resultSrcD = ResAlu;
        immSrcD_o  = ImmI;
        case (op_i)
            OpR: regWriteD = 1'b1;
            OpI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            OpLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = ResMem;
            end
            OpStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD_o = ImmS;
            end
            OpBranch: immSrcD_o = ImmB;
            OpJal: begin
                regWriteD  = 1'b1;
                resultSrcD = ResPcPlus4;
                immSrcD_o  = ImmJ;
            end
            OpLui: begin
                regWriteD  = 1'b1;
                resultSrcD = ResImm;
                immSrcD_o  = ImmU;
            end
            default: ;
        endcase
    end

    always_comb begin
        aluCtrlD = AluAdd;
        if (op_i == OpBranch) begin
            aluCtrlD = AluSub;
        end else if (op_i == OpR || op_i == OpI) begin
            case (funct3_i)
                3'b000:  aluCtrlD = (op_i == OpR && funct7b5_i) ? AluSub : AluAdd;
                3'b010:  aluCtrlD = AluSlt;
                3'b110:  aluCtrlD = AluOr;
                3'b111:  aluCtrlD = AluAnd;
                default: aluCtrlD = AluAdd;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////
    // Control pipeline
    always_ff @(posedge clk) begin
        if (reset || flushE_o) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSrcE <= ResAlu;
            aluSrcE_o  <= 1'b0;
            aluCtrlE_o <= AluAdd;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            resultSrcE <= resultSrcD;
            aluSrcE_o  <= aluSrcD;
            aluCtrlE_o <= aluCtrlD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM    <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= ResAlu;
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= ResAlu;
        end else begin
            regWriteM    <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE;
            regWriteW_o  <= regWriteM;
            resultSrcW_o <= resultSrcM_o;
        end
    end

    //////////////////////////////////////////////////////////////
    // Hazard unit
    function automatic fwdSelT forwardFor(input logic [4:0] rs);
        if (rs != 5'd0 && regWriteM && rs == rdM_i) begin
            return FwdMem;
        end else if (rs != 5'd0 && regWriteW_o && rs == rdW_i) begin
            return FwdWb;
        end
        return FwdNone;
    endfunction

    always_comb begin
        forwardAE_o = forwardFor(rs1E_i);
        forwardBE_o = forwardFor(rs2E_i);
    end

    // The Memory-stage forward path carries no load data, so a direct consumer waits a cycle
    assign loadUseD = (resultSrcE == ResMem) && (rdE_i != 5'd0) &&
                      (rdE_i == rs1D_i || rdE_i == rs2D_i);

    assign stallF_o = loadUseD;
    assign stallD_o = loadUseD;
    assign flushD_o = mispredictE_i;
    assign flushE_o = mispredictE_i || loadUseD;

endmodule

`default_nettype wire

// File: logic/rvDatapath.sv
`default_nettype none

module rvDatapath (
    input  logic                         clk,
    input  logic                         reset,
    output logic [31:0]                  imemAddr_o,
    input  logic [31:0]                  imemData_i,
    output logic [31:0]                  dmemAddr_o,
    output logic [31:0]                  dmemWData_o,
    input  logic [31:0]                  dmemRData_i,
    output logic [6:0]                   op_o,
    output logic [2:0]                   funct3_o,
    output logic                         funct7b5_o,
    output logic [4:0]                   rs1D_o,
    output logic [4:0]                   rs2D_o,
    output logic [4:0]                   rs1E_o,
    output logic [4:0]                   rs2E_o,
    output logic [4:0]                   rdE_o,
    output logic [4:0]                   rdM_o,
    output logic [4:0]                   rdW_o,
    output logic                         branchTakenE_o,
    output logic                         mispredictE_o,
    input  rvPkg::immSrcT                immSrcD_i,
    input  logic                         aluSrcE_i,
    input  rvPkg::aluCtrlT               aluCtrlE_i,
    input  rvPkg::resultSrcT             resultSrcM_i,
    input  rvPkg::resultSrcT             resultSrcW_i,
    input  logic                         regWriteW_i,
    input  rvPkg::fwdSelT                forwardAE_i,
    input  rvPkg::fwdSelT                forwardBE_i,
    input  logic                         stallF_i,
    input  logic                         stallD_i,
    input  logic                         flushD_i,
    input  logic                         flushE_i,
    input  logic                         predTakenF_i,
    input  logic [31:0]                  predTargetF_i,
    input  logic [rvPkg::NumGhrBits-1:0] phtIndexF_i,
    output logic                         updateE_o,
    output logic                         isBranchE_o,
    output logic [31:0]                  pcE_o,
    output logic [31:0]                  targetE_o,
    output logic [rvPkg::NumGhrBits-1:0] phtIndexE_o
);
    import rvPkg::*;

    logic [31:0]           pcF, pcPlus4F, pcNextF;
    logic [31:0]           instrD, pcD, pcPlus4D, rd1D, rd2D, immD;
    logic                  predTakenD;
    logic [NumGhrBits-1:0] phtIndexD;
    logic [31:0]           rd1E, rd2E, immE, pcPlus4E;
    logic                  isBranchE, isJumpE, predTakenE, zeroE;
    logic [31:0]           srcAE, srcBE, writeDataE, aluResultE, correctPcE;
    logic [31:0]           aluResultM, immM, pcPlus4M, forwardM;
    logic [31:0]           aluResultW, readDataW, immW, pcPlus4W, resultW;

    //////////////////////////////////////////////////////////////
    // Fetch
    assign pcPlus4F   = pcF + 32'd4;
    assign correctPcE = branchTakenE_o ? targetE_o : pcPlus4E;
    assign imemAddr_o = pcF;

    always_comb begin
        if (mispredictE_o) begin
            pcNextF = correctPcE;
        end else if (predTakenF_i) begin
            pcNextF = predTargetF_i;
        end else begin
            pcNextF = pcPlus4F;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= PcStart;
        end else if (!stallF_i) begin
            pcF <= pcNextF;
        end
    end

    //////////////////////////////////////////////////////////////
    // Decode
    // An all-zero instruction word matches no opcode and acts as the bubble
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= 32'h0;
            predTakenD <= 1'b0;
        end else if (!stallD_i) begin
            instrD     <= imemData_i;
            predTakenD <= predTakenF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD       <= pcF;
            pcPlus4D  <= pcPlus4F;
            phtIndexD <= phtIndexF_i;
        end
    end

    assign op_o       = instrD[6:0];
    assign funct3_o   = instrD[14:12];
    assign funct7b5_o = instrD[30];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];

    rvRegFile regFile (
        .clk(clk),
        .rs1_i(rs1D_o), .rs2_i(rs2D_o), .rd_i(rdW_o),
        .we_i(regWriteW_i), .wd_i(resultW),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    always_comb begin
        case (immSrcD_i)
            ImmI:    immD = {{20{instrD[31]}}, instrD[31:20]};
            ImmS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            ImmB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            ImmJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            ImmU:    immD = {instrD[31:12], 12'h0};
            default: immD = 32'h0;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // Execute
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rs1E_o     <= 5'd0;
            rs2E_o     <= 5'd0;
            rdE_o      <= 5'd0;
            isBranchE  <= 1'b0;
            isJumpE    <= 1'b0;
            predTakenE <= 1'b0;
        end else begin
            rs1E_o     <= rs1D_o;
            rs2E_o     <= rs2D_o;
            rdE_o      <= instrD[11:7];
            isBranchE  <= (op_o == OpBranch);
            isJumpE    <= (op_o == OpJal);
            predTakenE <= predTakenD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        immE        <= immD;
        pcE_o       <= pcD;
        pcPlus4E    <= pcPlus4D;
        phtIndexE_o <= phtIndexD;
    end

    always_comb begin
        case (forwardAE_i)
            FwdMem:  srcAE = forwardM;
            FwdWb:   srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardBE_i)
            FwdMem:  writeDataE = forwardM;
            FwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcE_i ? immE : writeDataE;

    rvAlu alu (
        .a_i(srcAE), .b_i(srcBE), .ctrl_i(aluCtrlE_i),
        .result_o(aluResultE), .zero_o(zeroE)
    );

    assign targetE_o      = pcE_o + immE;
    assign branchTakenE_o = isJumpE || (isBranchE && zeroE);
    // Covers both a missed taken branch and a wrongly taken one
    assign mispredictE_o  = (branchTakenE_o != predTakenE);
    assign updateE_o      = isBranchE || isJumpE;
    assign isBranchE_o    = isBranchE;

    //////////////////////////////////////////////////////////////
    // Memory and Writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            rdM_o <= 5'd0;
            rdW_o <= 5'd0;
        end else begin
            rdM_o <= rdE_o;
            rdW_o <= rdM_o;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM  <= aluResultE;
        dmemWData_o <= writeDataE;
        immM        <= immE;
        pcPlus4M    <= pcPlus4E;
        aluResultW  <= aluResultM;
        readDataW   <= dmemRData_i;
        immW        <= immM;
        pcPlus4W    <= pcPlus4M;
    end

    assign dmemAddr_o = aluResultM;

    always_comb begin
        case (resultSrcM_i)
            ResPcPlus4: forwardM = pcPlus4M;
            ResImm:     forwardM = immM;
            default:    forwardM = aluResultM;
        endcase
        case (resultSrcW_i)
            ResMem:     resultW = readDataW;
            ResPcPlus4: resultW = pcPlus4W;
            ResImm:     resultW = immW;
            default:    resultW = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rvCore.sv
`default_nettype none

module rvCore (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imemAddr_o,
    input  logic [31:0] imemData_i,
    output logic [31:0] dmemAddr_o,
    output logic [31:0] dmemWData_o,
    output logic        dmemWe_o,
    input  logic [31:0] dmemRData_i
);
    import rvPkg::*;

    logic [6:0]            op;
    logic [2:0]            funct3;
    logic                  funct7b5;
    logic [4:0]            rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    logic                  branchTakenE, mispredictE;
    immSrcT                immSrcD;
    aluCtrlT               aluCtrlE;
    resultSrcT             resultSrcM, resultSrcW;
    fwdSelT                forwardAE, forwardBE;
    logic                  aluSrcE, regWriteW;
    logic                  stallF, stallD, flushD, flushE;
    logic                  predTakenF, updateE, isBranchE;
    logic [31:0]           predTargetF, pcE, targetE;
    logic [NumGhrBits-1:0] phtIndexF, phtIndexE;

    rvDatapath datapath (
        .clk(clk), .reset(reset),
        .imemAddr_o(imemAddr_o), .imemData_i(imemData_i),
        .dmemAddr_o(dmemAddr_o), .dmemWData_o(dmemWData_o), .dmemRData_i(dmemRData_i),
        .op_o(op), .funct3_o(funct3), .funct7b5_o(funct7b5),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E),
        .rdE_o(rdE), .rdM_o(rdM), .rdW_o(rdW),
        .branchTakenE_o(branchTakenE), .mispredictE_o(mispredictE),
        .immSrcD_i(immSrcD), .aluSrcE_i(aluSrcE), .aluCtrlE_i(aluCtrlE),
        .resultSrcM_i(resultSrcM), .resultSrcW_i(resultSrcW), .regWriteW_i(regWriteW),
        .forwardAE_i(forwardAE), .forwardBE_i(forwardBE),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .predTakenF_i(predTakenF), .predTargetF_i(predTargetF), .phtIndexF_i(phtIndexF),
        .updateE_o(updateE), .isBranchE_o(isBranchE), .pcE_o(pcE),
        .targetE_o(targetE), .phtIndexE_o(phtIndexE)
    );

    rvController controller (
        .clk(clk), .reset(reset),
        .op_i(op), .funct3_i(funct3), .funct7b5_i(funct7b5),
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW), .mispredictE_i(mispredictE),
        .immSrcD_o(immSrcD), .aluSrcE_o(aluSrcE), .aluCtrlE_o(aluCtrlE),
        .resultSrcM_o(resultSrcM), .resultSrcW_o(resultSrcW),
        .memWriteM_o(dmemWe_o), .regWriteW_o(regWriteW),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE)
    );

    // The actual branch direction from Execute trains the predictor
    rvBranchPredictor predictor (
        .clk(clk), .reset(reset), .pcF_i(imemAddr_o),
        .predTakenF_o(predTakenF), .predTargetF_o(predTargetF), .phtIndexF_o(phtIndexF),
        .updateE_i(updateE), .isBranchE_i(isBranchE), .takenE_i(branchTakenE),
        .pcE_i(pcE), .targetE_i(targetE), .phtIndexE_i(phtIndexE)
    );

endmodule

`default_nettype wire

// File: verification/coreRefModel.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// The loop branch sits at word 37 and jumps back to word 34
localparam logic [31:0] LoopBranchPc   = 32'd148;
localparam logic [31:0] LoopTargetPc   = 32'd136;
localparam int          LoopTakenCount = 10;

////////////////////////////////////////////////////////////
// Instruction encoders
function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OpR};
endfunction

function automatic logic [31:0] iWord(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpStore};
endfunction

function automatic logic [31:0] bWord(input logic [4:0] rs1, input logic [4:0] rs2,
                                      input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OpBranch};
endfunction

function automatic logic [31:0] jWord(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OpJal};
endfunction

function automatic logic [31:0] uWord(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OpLui};
endfunction

////////////////////////////////////////////////////////////
// Program image
task automatic loadProgram();
    for (int i = 0; i < MemWords; i++) begin
        imem[i] = 32'h0;
    end
    // Forwarding chain over lui, addi and the R-type operations
    imem[0]  = uWord(5'd1, 20'h12345);
    imem[1]  = iWord(OpI, 3'b000, 5'd1, 5'd1, 12'h678);
    imem[2]  = iWord(OpI, 3'b000, 5'd2, 5'd0, 12'd100);
    imem[3]  = rWord(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    imem[4]  = rWord(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
    imem[5]  = rWord(7'h00, 3'b111, 5'd5, 5'd3, 5'd4);
    imem[6]  = rWord(7'h00, 3'b110, 5'd6, 5'd5, 5'd1);
    imem[7]  = rWord(7'h00, 3'b010, 5'd7, 5'd4, 5'd3);
    imem[8]  = sWord(5'd3, 5'd0, 12'h040);
    imem[9]  = sWord(5'd4, 5'd0, 12'h044);
    imem[10] = sWord(5'd6, 5'd0, 12'h048);
    imem[11] = sWord(5'd7, 5'd0, 12'h04c);
    // Loads consumed by the very next instruction
    imem[12] = iWord(OpLoad, 3'b010, 5'd8, 5'd0, 12'h010);
    imem[13] = rWord(7'h00, 3'b000, 5'd8, 5'd8, 5'd2);
    imem[14] = sWord(5'd8, 5'd0, 12'h050);
    imem[15] = iWord(OpLoad, 3'b010, 5'd12, 5'd0, 12'h014);
    imem[16] = sWord(5'd12, 5'd0, 12'h054);
    // Not-taken beq, then jal whose link is stored
    imem[17] = bWord(5'd1, 5'd2, 13'd8);
    imem[18] = sWord(5'd2, 5'd0, 12'h058);
    imem[19] = jWord(5'd13, 21'd8);
    imem[20] = sWord(5'd0, 5'd0, 12'h05c);
    imem[21] = sWord(5'd13, 5'd0, 12'h05c);
    // Four taken beqs leave the global history all ones before the loop
    imem[22] = bWord(5'd0, 5'd0, 13'd8);
    imem[23] = sWord(5'd1, 5'd0, 12'h060);
    imem[24] = bWord(5'd2, 5'd2, 13'd8);
    imem[25] = sWord(5'd1, 5'd0, 12'h060);
    imem[26] = bWord(5'd3, 5'd3, 13'd8);
    imem[27] = sWord(5'd1, 5'd0, 12'h060);
    imem[28] = bWord(5'd4, 5'd4, 13'd8);
    imem[29] = sWord(5'd1, 5'd0, 12'h060);
    imem[30] = iWord(OpI, 3'b000, 5'd5, 5'd0, 12'd0);
    imem[31] = iWord(OpI, 3'b000, 5'd6, 5'd0, 12'd11);
    imem[32] = iWord(OpI, 3'b000, 5'd8, 5'd0, 12'd1);
    imem[33] = iWord(OpI, 3'b000, 5'd10, 5'd0, 12'd0);
    // In the loop body the beq is taken while the counter is below 11
    imem[34] = iWord(OpI, 3'b000, 5'd5, 5'd5, 12'd1);
    imem[35] = rWord(7'h00, 3'b000, 5'd10, 5'd10, 5'd5);
    imem[36] = rWord(7'h00, 3'b010, 5'd7, 5'd5, 5'd6);
    imem[37] = bWord(5'd7, 5'd8, -13'd12);
    imem[38] = sWord(5'd10, 5'd0, 12'h064);
    imem[39] = sWord(5'd5, 5'd0, 12'h068);
    imem[40] = jWord(5'd0, 21'd0);
endtask

////////////////////////////////////////////////////////////
// Instruction-level reference
function automatic logic [31:0] arith(input logic [2:0] f3, input logic sub,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return 32'h0;
    endcase
endfunction

// Runs until the jal to itself and returns the number of executed instructions
function automatic int runReference();
    logic [31:0] x [32];
    logic [31:0] mem [MemWords];
    logic [31:0] pc, next, ins, a, b, ea;
    logic [4:0]  rd;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        x[i] = 32'h0;
    end
    for (int i = 0; i < MemWords; i++) begin
        mem[i] = dmemInit[i];
    end
    pc    = PcStart;
    steps = 0;
    while (imem[pc[AddrMsb:2]] != jWord(5'd0, 21'd0) && steps < MaxRefSteps) begin
        ins  = imem[pc[AddrMsb:2]];
        rd   = ins[11:7];
        a    = x[ins[19:15]];
        b    = x[ins[24:20]];
        next = pc + 32'd4;
        case (ins[6:0])
            OpR: x[rd] = arith(ins[14:12], ins[30], a, b);
            OpI: x[rd] = arith(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
            OpLoad: begin
                ea    = a + {{20{ins[31]}}, ins[31:20]};
                x[rd] = mem[ea[AddrMsb:2]];
            end
            OpStore: begin
                ea                 = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem[ea[AddrMsb:2]] = b;
                expAddr.push_back(ea);
                expData.push_back(b);
            end
            OpBranch: begin
                if (a == b) begin
                    next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OpJal: begin
                x[rd] = pc + 32'd4;
                next  = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OpLui: x[rd] = {ins[31:12], 12'h0};
            default: ;
        endcase
        x[0]  = 32'h0;
        pc    = next;
        steps = steps + 1;
    end
    return steps;
endfunction

`endif

// File: verification/coreTb.sv
`default_nettype none

module coreTb;
    import rvPkg::*;

    localparam int ClkHalf     = 4;
    localparam int ResetCycles = 8;
    localparam int MemWords    = 64;
    localparam int AddrMsb     = $clog2(MemWords) + 1;
    localparam int MaxRefSteps = 1000;

    logic        clk   = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] imemAddr, imemData, dmemAddr, dmemWData, dmemRData;
    logic        dmemWe;

    logic [31:0] imem     [MemWords];
    logic [31:0] dmem     [MemWords];
    logic [31:0] dmemInit [MemWords];
    logic [31:0] expAddr  [$];
    logic [31:0] expData  [$];
    int          refSteps;
    int          expCount;
    logic        refReady       = 1'b0;
    int          storeCount     = 0;
    int          loopFetches    = 0;
    logic        firstFetchSeen = 1'b0;
    logic [31:0] lastFetch      = 32'hffff_ffff;
    logic        pendWe         = 1'b0;
    logic [31:0] pendAddr, pendData;
    integer      seed;

    `include "coreRefModel.svh"

    rvCore dut0 (
        .clk(clk), .reset(reset),
        .imemAddr_o(imemAddr), .imemData_i(imemData),
        .dmemAddr_o(dmemAddr), .dmemWData_o(dmemWData), .dmemWe_o(dmemWe),
        .dmemRData_i(dmemRData)
    );

    always #ClkHalf clk = ~clk;

    // Both memories answer in the same cycle
    assign imemData  = imem[imemAddr[AddrMsb:2]];
    assign dmemRData = dmem[dmemAddr[AddrMsb:2]];

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compareStore(input logic [31:0] wantAddr, input logic [31:0] wantData,
                                input logic [31:0] gotAddr, input logic [31:0] gotData);
        if (gotAddr !== wantAddr) begin
            abortRun($sformatf("Mismatch at %0t: dmemAddr_o expected %h, actual %h",
                               $time, wantAddr, gotAddr));
        end
        if (gotData !== wantData) begin
            abortRun($sformatf("Mismatch at %0t: dmemWData_o expected %h, actual %h",
                               $time, wantData, gotData));
        end
    endtask

    task automatic compareFetch(input logic [31:0] wantPc, input logic [31:0] gotPc);
        if (gotPc !== wantPc) begin
            abortRun($sformatf("Mismatch at %0t: imemAddr_o expected %h, actual %h",
                               $time, wantPc, gotPc));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Memory models and reference run
    initial begin
        seed = 32'h72f3;
        for (int i = 0; i < MemWords; i++) begin
            dmemInit[i] = $random(seed);
            dmem[i]     = dmemInit[i];
        end
        loadProgram();
        refSteps = runReference();
        expCount = expAddr.size();
        refReady = 1'b1;
        forever begin
            @(posedge clk);
            // A store latched at the falling edge lands on this rising edge
            if (pendWe) begin
                dmem[pendAddr[AddrMsb:2]] = pendData;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checker that samples between rising edges
    always @(negedge clk) begin
        if (reset) begin
            if (dmemWe === 1'b1) begin
                abortRun("The data memory write enable was high during reset");
            end
        end else begin
            if (!firstFetchSeen) begin
                compareFetch(PcStart, imemAddr);
                firstFetchSeen = 1'b1;
            end
            // Once trained, the fetch right after the loop branch is the loop target
            if (lastFetch == LoopBranchPc) begin
                loopFetches = loopFetches + 1;
                if (loopFetches >= 4 && loopFetches <= LoopTakenCount) begin
                    compareFetch(LoopTargetPc, imemAddr);
                end
            end
            lastFetch = imemAddr;
            if (dmemWe === 1'b1) begin
                if (storeCount >= expCount) begin
                    abortRun("The core wrote more stores than the reference program makes");
                end else begin
                    compareStore(expAddr[storeCount], expData[storeCount], dmemAddr, dmemWData);
                    storeCount = storeCount + 1;
                end
            end else if (dmemWe !== 1'b0) begin
                abortRun("The data memory write enable is unknown after reset");
            end
        end
        pendWe   = (dmemWe === 1'b1) && !reset;
        pendAddr = dmemAddr;
        pendData = dmemWData;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    initial begin
        wait (refReady);
        if (refSteps >= MaxRefSteps) begin
            abortRun("The reference model never reached the end of the program");
        end
        repeat (ResetCycles) @(posedge clk);
        #1 reset = 1'b0;
        wait (storeCount == expCount);
        if (loopFetches < LoopTakenCount + 1) begin
            abortRun("The loop branch was fetched fewer times than it executes");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    initial begin
        wait (refReady);
        repeat (ResetCycles + refSteps * 4 + 100) @(posedge clk);
        abortRun("Timeout: the core stopped storing before the expected stores were seen");
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verification
logic/rvPkg.sv
logic/rvRegFile.sv
logic/rvAlu.sv
logic/rvBranchPredictor.sv
logic/rvController.sv
logic/rvDatapath.sv
logic/rvCore.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module coreTb -f sim.f -o coreTbSim &&
{ simOut="$(./obj_dir/coreTbSim)"; printf '%s\n' "$simOut";
  printf '%s\n' "$simOut" | grep -q "All tests passed"; } ||
{ echo "Simulation FAILED"; exit 1; }
